//--- filelist.f
rtl/csr_pkg.sv
rtl/csr_addr_decode.sv
rtl/csr_trap_regs.sv
rtl/csr_machine_regs.sv
rtl/csr_read_mux.sv
rtl/csr_file.sv
testbench/tb_clock_gen.sv
testbench/tb_csr_file.sv

//--- rtl/csr_addr_decode.sv
// ----------------------------------------
// CSR address decoder. Raises one select bit
// for the addressed register, all zero when
// the access strobe is low
// ----------------------------------------
`timescale 1ns/100ps

module csr_addr_decode import csr_pkg::*; (
    input  csr_req_t csr,
    output csr_sel_t sel
);

    csr_sel_t match;

    always_comb begin
        match = '0;
        match.mstatus       = (csr.addr == csr_addr_mstatus);
        match.misa          = (csr.addr == csr_addr_misa);
        match.mtvec         = (csr.addr == csr_addr_mtvec);
        match.mcountinhibit = (csr.addr == csr_addr_mcountinhibit);
        match.mscratch      = (csr.addr == csr_addr_mscratch);
        match.mepc          = (csr.addr == csr_addr_mepc);
        match.mcause        = (csr.addr == csr_addr_mcause);
        match.mtval         = (csr.addr == csr_addr_mtval);

        // Counter halves, user aliases
        match.cycle         = (csr.addr == csr_addr_cycle);
        match.cycleh        = (csr.addr == csr_addr_cycleh);
        match.instret       = (csr.addr == csr_addr_instret);
        match.instreth      = (csr.addr == csr_addr_instreth);

        // Counter halves, machine aliases
        match.mcycle        = (csr.addr == csr_addr_mcycle);
        match.mcycleh       = (csr.addr == csr_addr_mcycleh);
        match.minstret      = (csr.addr == csr_addr_minstret);
        match.minstreth     = (csr.addr == csr_addr_minstreth);

        match.mvendorid     = (csr.addr == csr_addr_mvendorid);
        match.marchid       = (csr.addr == csr_addr_marchid);
        match.mimpid        = (csr.addr == csr_addr_mimpid);
        match.mhartid       = (csr.addr == csr_addr_mhartid);
    end

    assign sel = csr.en ? match : '0;       // No access, no select

endmodule

//--- rtl/csr_file.sv
// ----------------------------------------
// Machine-mode CSR file, top level. Reads are
// combinational, writes, traps and MRET take
// effect on the next clock edge
// ----------------------------------------
`timescale 1ns/100ps

module csr_file import csr_pkg::*; #(
    parameter csr_data_t mtvec_reset = 32'hC000_0000,
    parameter csr_data_t mvendorid   = '0,
    parameter csr_data_t marchid     = '0,
    parameter csr_data_t mimpid      = '0,
    parameter csr_data_t mhartid     = '0
) (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  csr_req_t  csr,
    input  trap_req_t trap,
    input  logic      exec_mret,
    input  counters_t ctr,
    output csr_data_t rdata,
    output csr_data_t mepc,
    output csr_data_t mtvec,
    output inhibit_t  inhibit
);

    csr_sel_t  sel;
    mstatus_t  mstatus;
    csr_data_t mcause;
    csr_data_t mtval;
    csr_data_t mscratch;

    csr_addr_decode addr_decode_inst (
        .csr (csr),
        .sel (sel)
    );

    csr_trap_regs trap_regs_inst (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .csr       (csr),
        .sel       (sel),
        .trap      (trap),
        .exec_mret (exec_mret),
        .mstatus   (mstatus),
        .mepc      (mepc),
        .mcause    (mcause),
        .mtval     (mtval)
    );

    csr_machine_regs #(
        .mtvec_reset (mtvec_reset)
    ) machine_regs_inst (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .csr      (csr),
        .sel      (sel),
        .mtvec    (mtvec),
        .mscratch (mscratch),
        .inhibit  (inhibit)
    );

    csr_read_mux #(
        .mvendorid (mvendorid),
        .marchid   (marchid),
        .mimpid    (mimpid),
        .mhartid   (mhartid)
    ) read_mux_inst (
        .sel      (sel),
        .ctr      (ctr),
        .mstatus  (mstatus),
        .mepc     (mepc),
        .mcause   (mcause),
        .mtval    (mtval),
        .mtvec    (mtvec),
        .mscratch (mscratch),
        .inhibit  (inhibit),
        .rdata    (rdata)
    );

endmodule

//--- rtl/csr_machine_regs.sv
// ----------------------------------------
// Software-only machine CSRs: mtvec in direct
// mode, mscratch and mcountinhibit, which also
// drives the counter inhibit outputs
// ----------------------------------------
`timescale 1ns/100ps

module csr_machine_regs import csr_pkg::*; #(
    parameter csr_data_t mtvec_reset = '0
) (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  csr_req_t  csr,
    input  csr_sel_t  sel,
    output csr_data_t mtvec,
    output csr_data_t mscratch,
    output inhibit_t  inhibit
);

    csr_data_t mcountinhibit;
    csr_data_t mcountinhibit_wr;

    // cy at bit 0, ir at bit 2, time bit reads as zero
    assign mcountinhibit    = {{(xlen-3){1'b0}}, inhibit.ir, 1'b0, inhibit.cy};
    assign mcountinhibit_wr = csr_merge(mcountinhibit, csr);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec <= mtvec_reset & ~csr_data_t'(3);
        end else if (csr.wr && sel.mtvec) begin
            mtvec <= csr_merge(mtvec, csr) & ~csr_data_t'(3);   // Direct mode only
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch <= '0;
        end else if (csr.wr && sel.mscratch) begin
            mscratch <= csr_merge(mscratch, csr);
        end
    end

    // ----------------------------------------
    // Counter inhibit
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            inhibit <= '0;
        end else if (csr.wr && sel.mcountinhibit) begin
            inhibit.cy <= mcountinhibit_wr[0];
            inhibit.ir <= mcountinhibit_wr[2];
        end
    end

endmodule

//--- rtl/csr_pkg.sv
// ----------------------------------------
// Shared types, addresses and helpers of the
// machine-mode CSR file. Every RTL module takes
// what it needs by a wildcard import
// ----------------------------------------
package csr_pkg;

    localparam int xlen = 32;

    typedef logic [11:0]     csr_addr_t;
    typedef logic [xlen-1:0] csr_data_t;
    typedef logic [5:0]      trap_code_t;

    // ----------------------------------------
    // CSR addresses
    // ----------------------------------------
    localparam csr_addr_t csr_addr_mstatus       = 12'h300;
    localparam csr_addr_t csr_addr_misa          = 12'h301;
    localparam csr_addr_t csr_addr_mtvec         = 12'h305;
    localparam csr_addr_t csr_addr_mcountinhibit = 12'h320;
    localparam csr_addr_t csr_addr_mscratch      = 12'h340;
    localparam csr_addr_t csr_addr_mepc          = 12'h341;
    localparam csr_addr_t csr_addr_mcause        = 12'h342;
    localparam csr_addr_t csr_addr_mtval         = 12'h343;

    localparam csr_addr_t csr_addr_cycle         = 12'hC00; // User read-only aliases
    localparam csr_addr_t csr_addr_instret       = 12'hC02;
    localparam csr_addr_t csr_addr_cycleh        = 12'hC80;
    localparam csr_addr_t csr_addr_instreth      = 12'hC82;

    localparam csr_addr_t csr_addr_mcycle        = 12'hB00; // Machine aliases
    localparam csr_addr_t csr_addr_minstret      = 12'hB02;
    localparam csr_addr_t csr_addr_mcycleh       = 12'hB80;
    localparam csr_addr_t csr_addr_minstreth     = 12'hB82;

    localparam csr_addr_t csr_addr_mvendorid     = 12'hF11;
    localparam csr_addr_t csr_addr_marchid       = 12'hF12;
    localparam csr_addr_t csr_addr_mimpid        = 12'hF13;
    localparam csr_addr_t csr_addr_mhartid       = 12'hF14;

    // ----------------------------------------
    // Exception codes
    // ----------------------------------------
    localparam trap_code_t trap_ialign   = 6'd0;
    localparam trap_code_t trap_iaccess  = 6'd1;
    localparam trap_code_t trap_iopcode  = 6'd2;
    localparam trap_code_t trap_breakpt  = 6'd3;
    localparam trap_code_t trap_ldalign  = 6'd4;
    localparam trap_code_t trap_ldaccess = 6'd5;
    localparam trap_code_t trap_stalign  = 6'd6;
    localparam trap_code_t trap_staccess = 6'd7;
    localparam trap_code_t trap_ecallm   = 6'd11;

    // MXL = 1 (32 bit), extensions I (bit 8) and M (bit 12)
    localparam csr_data_t misa_value = {2'b01, 17'b0, 1'b1, 3'b0, 1'b1, 8'b0};

    typedef struct packed {
        logic      en;                  // Access strobe
        logic      wr;                  // Write, implies en
        logic      set;                 // Bit set variant
        logic      clr;                 // Bit clear variant
        csr_addr_t addr;
        csr_data_t wdata;
    } csr_req_t;

    typedef struct packed {
        logic       cpu;                // Exception from the pipeline
        logic       irq;                // Interrupt
        trap_code_t cause;
        csr_data_t  mtval;
        csr_data_t  pc;
    } trap_req_t;

    typedef struct packed {
        logic mstatus;
        logic misa;
        logic mtvec;
        logic mcountinhibit;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic cycle;
        logic cycleh;
        logic instret;
        logic instreth;
        logic mcycle;
        logic mcycleh;
        logic minstret;
        logic minstreth;
        logic mvendorid;
        logic marchid;
        logic mimpid;
        logic mhartid;
    } csr_sel_t;

    typedef struct packed {
        logic       sd;
        logic [7:0] wpri1;
        logic       tsr;
        logic       tw;
        logic       tvm;
        logic       mxr;
        logic       sum;
        logic       mprv;
        logic [1:0] xs;
        logic [1:0] fs;
        logic [1:0] mpp;
        logic [1:0] wpri2;
        logic       spp;
        logic       mpie;               // Bit 7
        logic       wpri3;
        logic       spie;
        logic       upie;
        logic       mie;                // Bit 3
        logic       wpri4;
        logic       sie;
        logic       uie;
    } mstatus_t;

    typedef struct packed {
        logic [63:0] cycle;
        logic [63:0] instret;
    } counters_t;

    typedef struct packed {
        logic cy;
        logic ir;
    } inhibit_t;

    // New register value for a write, set or clear access
    function automatic csr_data_t csr_merge(csr_data_t old, csr_req_t req);
        if (req.set) begin
            return old | req.wdata;
        end else if (req.clr) begin
            return old & ~req.wdata;
        end
        return req.wdata;
    endfunction

endpackage

//--- rtl/csr_read_mux.sv
// ----------------------------------------
// CSR read data path. AND-OR of every selected
// source, counter halves and constant IDs.
// Purely combinational
// ----------------------------------------
`timescale 1ns/100ps

module csr_read_mux import csr_pkg::*; #(
    parameter csr_data_t mvendorid = '0,
    parameter csr_data_t marchid   = '0,
    parameter csr_data_t mimpid    = '0,
    parameter csr_data_t mhartid   = '0
) (
    input  csr_sel_t  sel,
    input  counters_t ctr,
    input  mstatus_t  mstatus,
    input  csr_data_t mepc,
    input  csr_data_t mcause,
    input  csr_data_t mtval,
    input  csr_data_t mtvec,
    input  csr_data_t mscratch,
    input  inhibit_t  inhibit,
    output csr_data_t rdata
);

    csr_data_t mcountinhibit;
    logic      rd_cycle_lo;
    logic      rd_cycle_hi;
    logic      rd_instret_lo;
    logic      rd_instret_hi;

    assign mcountinhibit = {{(xlen-3){1'b0}}, inhibit.ir, 1'b0, inhibit.cy};

    // User and machine aliases share the same counter halves
    assign rd_cycle_lo   = sel.cycle    | sel.mcycle;
    assign rd_cycle_hi   = sel.cycleh   | sel.mcycleh;
    assign rd_instret_lo = sel.instret  | sel.minstret;
    assign rd_instret_hi = sel.instreth | sel.minstreth;

    // ----------------------------------------
    // Read data
    // ----------------------------------------
    assign rdata =
        ({xlen{sel.mstatus}}       & csr_data_t'(mstatus))   |
        ({xlen{sel.misa}}          & misa_value)             |
        ({xlen{sel.mtvec}}         & mtvec)                  |
        ({xlen{sel.mcountinhibit}} & mcountinhibit)          |
        ({xlen{sel.mscratch}}      & mscratch)               |
        ({xlen{sel.mepc}}          & mepc)                   |
        ({xlen{sel.mcause}}        & mcause)                 |
        ({xlen{sel.mtval}}         & mtval)                  |
        ({xlen{rd_cycle_lo}}       & ctr.cycle[31:0])        |
        ({xlen{rd_cycle_hi}}       & ctr.cycle[63:32])       |
        ({xlen{rd_instret_lo}}     & ctr.instret[31:0])      |
        ({xlen{rd_instret_hi}}     & ctr.instret[63:32])     |
        ({xlen{sel.mvendorid}}     & mvendorid)              |
        ({xlen{sel.marchid}}       & marchid)                |
        ({xlen{sel.mimpid}}        & mimpid)                 |
        ({xlen{sel.mhartid}}       & mhartid);               // Unknown address gives zero

endmodule

//--- rtl/csr_trap_regs.sv
// ----------------------------------------
// Trap related CSRs: mstatus, mepc, mcause
// and mtval. Updated by trap entry, MRET and
// CSR accesses, one clock after the request
// ----------------------------------------
`timescale 1ns/100ps

module csr_trap_regs import csr_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  csr_req_t  csr,
    input  csr_sel_t  sel,
    input  trap_req_t trap,
    input  logic      exec_mret,
    output mstatus_t  mstatus,
    output csr_data_t mepc,
    output csr_data_t mcause,
    output csr_data_t mtval
);

    logic      mie_q;
    logic      mpie_q;
    logic      trap_any;
    logic      wr_mstatus;
    logic      wr_mepc;
    logic      wr_mcause;
    logic      wr_mtval;
    logic      cause_legal;
    mstatus_t  mstatus_wr;
    csr_data_t mcause_wr;

    assign trap_any   = trap.cpu | trap.irq;
    assign wr_mstatus = csr.wr & sel.mstatus;
    assign wr_mepc    = csr.wr & sel.mepc;
    assign wr_mcause  = csr.wr & sel.mcause & cause_legal;
    assign wr_mtval   = csr.wr & sel.mtval;

    // Only the nine supported exception codes may be written
    assign cause_legal = (csr.wdata[xlen-1:6] == '0) &&
                         (csr.wdata[5:0] inside {trap_ialign, trap_iaccess, trap_iopcode,
                                                 trap_breakpt, trap_ldalign, trap_ldaccess,
                                                 trap_stalign, trap_staccess, trap_ecallm});

    assign mstatus_wr = mstatus_t'(csr_merge(mstatus, csr));

    always_comb begin
        mcause_wr         = csr_merge(mcause, csr);
        mcause_wr[xlen-1] = 1'b0;               // Software write is never an interrupt
    end

    // ----------------------------------------
    // mstatus
    // ----------------------------------------
    always_comb begin
        mstatus      = '0;                      // Unimplemented fields read as zero
        mstatus.mie  = mie_q;
        mstatus.mpie = mpie_q;
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
        end else if (trap_any) begin
            mpie_q <= mie_q;                    // Stack the enable
            mie_q  <= 1'b0;
        end else if (exec_mret) begin
            mie_q  <= mpie_q;                   // Restore the enable
            mpie_q <= 1'b0;
        end else if (wr_mstatus) begin
            mie_q  <= mstatus_wr.mie;
            mpie_q <= mstatus_wr.mpie;
        end
    end

    // ----------------------------------------
    // mepc, mcause, mtval
    // ----------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mepc <= '0;
        end else if (trap_any) begin
            mepc <= {trap.pc[xlen-1:1], 1'b0};
        end else if (wr_mepc) begin
            mepc <= {csr_merge(mepc, csr)} & ~csr_data_t'(1);    // Halfword aligned
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mcause <= '0;
        end else if (trap_any) begin
            mcause <= {trap.irq, {(xlen-7){1'b0}}, trap.cause};
        end else if (wr_mcause) begin
            mcause <= mcause_wr;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtval <= '0;
        end else if (trap.cpu) begin
            mtval <= trap.mtval;                // Interrupts leave mtval alone
        end else if (wr_mtval) begin
            mtval <= csr_merge(mtval, csr);
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the CSR file testbench with Verilator and run it.
# The exit status is the simulator's, nonzero on any failure.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f filelist.f --top-module tb_csr_file -o tb_csr_file
./obj_dir/tb_csr_file

//--- testbench/tb_clock_gen.sv
// ----------------------------------------
// Testbench clock and reset source. Free
// running clock, reset held for a number of
// cycles and released on a rising edge
// ----------------------------------------
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 8
) (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #(period / 2) g_clk = ~g_clk;
    end

    initial begin
        g_resetn <= 1'b0;
        repeat (reset_cycles) @(posedge g_clk);
        g_resetn <= 1'b1;                   // Release on a rising edge
    end

endmodule

//--- testbench/tb_csr_file.sv
// ----------------------------------------
// Directed testbench of the machine-mode CSR
// file. Drives CSR accesses, traps and MRET
// and checks reads and outputs against values
// worked out from the CSR rules
// ----------------------------------------
`timescale 1ns/100ps

module tb_csr_file import csr_pkg::*; ();

    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    localparam int rw_rounds    = 4;
    // Rough length of all tests in clock cycles
    localparam int test_cycles  = reset_cycles + 15 + rw_rounds * 9 * 4 + 40 + 30 + 20 + 30;

    logic        g_clk;
    logic        g_resetn;
    csr_req_t    csr;
    trap_req_t   trap;
    logic        exec_mret;
    counters_t   ctr;
    csr_data_t   rdata;
    csr_data_t   mepc;
    csr_data_t   mtvec;
    inhibit_t    inhibit;
    logic [31:0] rng_state;

    tb_clock_gen #(
        .period       (clk_period),
        .reset_cycles (reset_cycles)
    ) clock_gen_inst (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    csr_file #(
        .mtvec_reset (32'hC000_0000),
        .mhartid     (32'd5)
    ) csr_file_inst (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .csr       (csr),
        .trap      (trap),
        .exec_mret (exec_mret),
        .ctr       (ctr),
        .rdata     (rdata),
        .mepc      (mepc),
        .mtvec     (mtvec),
        .inhibit   (inhibit)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // mie at bit 3, mpie at bit 7
    function automatic csr_data_t status_word(input logic mie, input logic mpie);
        return {24'b0, mpie, 3'b0, mie, 3'b0};
    endfunction

    task automatic check_value(input csr_data_t actual, input csr_data_t expected,
                               input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            $display("test failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Combinational read sampled on the falling edge
    task automatic read_csr(input csr_addr_t addr, output csr_data_t data);
        csr_req_t req;
        req      = '0;
        req.en   = 1'b1;
        req.addr = addr;
        @(posedge g_clk);
        csr <= req;
        @(negedge g_clk);
        data = rdata;
    endtask

    task automatic expect_read(input csr_addr_t addr, input csr_data_t expected,
                               input string msg);
        csr_data_t data;
        read_csr(addr, data);
        check_value(data, expected, msg);
    endtask

    // Write, set or clear captured on the second edge
    task automatic access_csr(input csr_addr_t addr, input csr_data_t data,
                              input logic set, input logic clr);
        csr_req_t req;
        req       = '0;
        req.en    = 1'b1;
        req.wr    = 1'b1;
        req.set   = set;
        req.clr   = clr;
        req.addr  = addr;
        req.wdata = data;
        @(posedge g_clk);
        csr <= req;
        @(posedge g_clk);
        csr <= '0;
    endtask

    task automatic raise_trap(input logic cpu, input logic irq, input trap_code_t cause,
                              input csr_data_t tval, input csr_data_t pc);
        trap_req_t req;
        req.cpu   = cpu;
        req.irq   = irq;
        req.cause = cause;
        req.mtval = tval;
        req.pc    = pc;
        @(posedge g_clk);
        trap <= req;
        @(posedge g_clk);
        trap <= '0;
    endtask

    task automatic pulse_mret();
        @(posedge g_clk);
        exec_mret <= 1'b1;
        @(posedge g_clk);
        exec_mret <= 1'b0;
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic reset_values();
        expect_read(csr_addr_mtvec, 32'hC000_0000, "mtvec after reset");
        check_value(mtvec, 32'hC000_0000, "mtvec output after reset");
        expect_read(csr_addr_mepc, 32'h0, "mepc after reset");
        expect_read(csr_addr_mcause, 32'h0, "mcause after reset");
        expect_read(csr_addr_mtval, 32'h0, "mtval after reset");
        expect_read(csr_addr_mscratch, 32'h0, "mscratch after reset");
        expect_read(csr_addr_mstatus, 32'h0, "mstatus after reset");
        expect_read(csr_addr_mcountinhibit, 32'h0, "mcountinhibit after reset");
        check_value({30'b0, inhibit}, 32'h0, "inhibit after reset");
        expect_read(csr_addr_misa, 32'h4000_1100, "misa is RV32IM");
        expect_read(csr_addr_mhartid, 32'd5, "mhartid");
        expect_read(12'h344, 32'h0, "dropped mip address");
    endtask

    task automatic write_set_clear();
        csr_addr_t addr [3];
        csr_data_t mask [3];
        csr_data_t expected [3];
        csr_data_t data;
        addr     = '{csr_addr_mscratch, csr_addr_mtvec, csr_addr_mepc};
        mask     = '{32'hFFFF_FFFF, 32'hFFFF_FFFC, 32'hFFFF_FFFE};
        expected = '{32'h0, 32'hC000_0000, 32'h0};
        for (int round = 0; round < rw_rounds; round++) begin
            for (int r = 0; r < 3; r++) begin
                for (int op = 0; op < 3; op++) begin
                    data = next_random();
                    case (op)
                        0:       expected[r] = data & mask[r];
                        1:       expected[r] = (expected[r] | data) & mask[r];
                        default: expected[r] = expected[r] & ~data;
                    endcase
                    access_csr(addr[r], data, op == 1, op == 2);
                    expect_read(addr[r], expected[r], "write, set or clear read back");
                end
            end
        end
        check_value(mtvec, expected[1], "mtvec output");
        check_value(mepc, expected[2], "mepc output");
    endtask

    task automatic trap_entry();
        csr_data_t pc;
        csr_data_t tval;
        csr_req_t  req;
        trap_req_t event_req;
        access_csr(csr_addr_mstatus, 32'h0000_0008, 1'b0, 1'b0);
        expect_read(csr_addr_mstatus, status_word(1'b1, 1'b0), "mstatus with mie set");

        pc   = next_random() | 32'h1;       // Odd pc so bit 0 must drop
        tval = next_random();
        raise_trap(1'b1, 1'b0, trap_ldaccess, tval, pc);
        expect_read(csr_addr_mepc, pc & ~32'h1, "mepc after cpu trap");
        check_value(mepc, pc & ~32'h1, "mepc output after cpu trap");
        expect_read(csr_addr_mcause, 32'd5, "mcause after cpu trap");
        expect_read(csr_addr_mtval, tval, "mtval after cpu trap");
        expect_read(csr_addr_mstatus, status_word(1'b0, 1'b1), "mstatus after cpu trap");

        pc = next_random();
        raise_trap(1'b0, 1'b1, 6'd7, next_random(), pc);     // Machine timer interrupt
        expect_read(csr_addr_mcause, 32'h8000_0007, "mcause after interrupt");
        expect_read(csr_addr_mtval, tval, "mtval kept on interrupt");
        expect_read(csr_addr_mepc, pc & ~32'h1, "mepc after interrupt");
        expect_read(csr_addr_mstatus, 32'h0, "mstatus after interrupt");

        // Trap and mepc write in the same cycle
        pc        = next_random();
        tval      = next_random();
        req       = '0;
        req.en    = 1'b1;
        req.wr    = 1'b1;
        req.addr  = csr_addr_mepc;
        req.wdata = next_random();
        event_req = '{cpu: 1'b1, irq: 1'b0, cause: trap_iopcode, mtval: tval, pc: pc};
        @(posedge g_clk);
        csr  <= req;
        trap <= event_req;
        @(posedge g_clk);
        csr  <= '0;
        trap <= '0;
        expect_read(csr_addr_mepc, pc & ~32'h1, "trap wins over mepc write");
        expect_read(csr_addr_mcause, 32'd2, "mcause of illegal opcode");
        expect_read(csr_addr_mtval, tval, "mtval of illegal opcode");
    endtask

    task automatic mret_return();
        access_csr(csr_addr_mstatus, 32'h0000_0088, 1'b0, 1'b0);
        expect_read(csr_addr_mstatus, status_word(1'b1, 1'b1), "mstatus write");
        access_csr(csr_addr_mstatus, 32'h0000_0008, 1'b0, 1'b1);
        expect_read(csr_addr_mstatus, status_word(1'b0, 1'b1), "mstatus clear of mie");
        pulse_mret();
        expect_read(csr_addr_mstatus, status_word(1'b1, 1'b0), "first mret");
        raise_trap(1'b1, 1'b0, trap_breakpt, next_random(), next_random());
        expect_read(csr_addr_mstatus, status_word(1'b0, 1'b1), "trap before mret");
        pulse_mret();
        expect_read(csr_addr_mstatus, status_word(1'b1, 1'b0), "mret after trap");
        pulse_mret();
        expect_read(csr_addr_mstatus, 32'h0, "mret with mpie clear");
        access_csr(csr_addr_mstatus, 32'h0000_0080, 1'b1, 1'b0);
        expect_read(csr_addr_mstatus, status_word(1'b0, 1'b1), "mstatus set of mpie");
    endtask

    task automatic mcause_filter();
        access_csr(csr_addr_mcause, {26'b0, trap_ecallm}, 1'b0, 1'b0);
        expect_read(csr_addr_mcause, 32'd11, "mcause write of ecall");
        access_csr(csr_addr_mcause, 32'd9, 1'b0, 1'b0);
        expect_read(csr_addr_mcause, 32'd11, "unsupported code 9 ignored");
        access_csr(csr_addr_mcause, 32'h8000_0003, 1'b0, 1'b0);
        expect_read(csr_addr_mcause, 32'd11, "interrupt cause write ignored");
        access_csr(csr_addr_mcause, 32'd2, 1'b0, 1'b0);
        expect_read(csr_addr_mcause, 32'd2, "mcause write of illegal opcode");
    endtask

    task automatic counters_inhibit();
        counters_t value;
        value.cycle   = {next_random(), next_random()};
        value.instret = {next_random(), next_random()};
        @(posedge g_clk);
        ctr <= value;
        expect_read(csr_addr_cycle, value.cycle[31:0], "cycle");
        expect_read(csr_addr_cycleh, value.cycle[63:32], "cycleh");
        expect_read(csr_addr_instret, value.instret[31:0], "instret");
        expect_read(csr_addr_instreth, value.instret[63:32], "instreth");
        expect_read(csr_addr_mcycle, value.cycle[31:0], "mcycle");
        expect_read(csr_addr_mcycleh, value.cycle[63:32], "mcycleh");
        expect_read(csr_addr_minstret, value.instret[31:0], "minstret");
        expect_read(csr_addr_minstreth, value.instret[63:32], "minstreth");

        access_csr(csr_addr_mcountinhibit, 32'h0000_0005, 1'b0, 1'b0);
        expect_read(csr_addr_mcountinhibit, 32'h5, "mcountinhibit cy and ir");
        check_value({31'b0, inhibit.cy}, 32'h1, "inhibit cy set");
        check_value({31'b0, inhibit.ir}, 32'h1, "inhibit ir set");
        access_csr(csr_addr_mcountinhibit, 32'h0000_0001, 1'b0, 1'b0);
        expect_read(csr_addr_mcountinhibit, 32'h1, "mcountinhibit cy only");
        check_value({31'b0, inhibit.ir}, 32'h0, "inhibit ir clear");
        access_csr(csr_addr_mcountinhibit, 32'h0000_0004, 1'b1, 1'b0);
        expect_read(csr_addr_mcountinhibit, 32'h5, "mcountinhibit set of ir");
        access_csr(csr_addr_mcountinhibit, 32'hFFFF_FFFF, 1'b0, 1'b1);
        expect_read(csr_addr_mcountinhibit, 32'h0, "mcountinhibit clear all");
        check_value({30'b0, inhibit}, 32'h0, "inhibit cleared");
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        csr        <= '0;
        trap       <= '0;
        exec_mret  <= 1'b0;
        ctr        <= '0;
        rng_state  = 32'h4f2655a0;
        while (g_resetn !== 1'b1) @(posedge g_clk);
        reset_values();
        write_set_clear();
        trap_entry();
        mret_return();
        mcause_filter();
        counters_inhibit();
        $display("test passed");
        $finish;
    end

    initial begin
        #(2 * test_cycles * clk_period);
        $display("Watchdog expired before the tests completed");
        $display("test failed");
        $fatal(1, "Timeout");
    end

endmodule
